/* design/loc_pkg.sv */
package loc_pkg;

    localparam int LAG_W    = 6;  // one correlation lag, centered at 32
    localparam int BAND_W   = 9;  // loudness band
    localparam int NUM_LAGS = 4;
    localparam int STATUS_W = 32;

    // lag view, lag1 in the top field down to lag4
    typedef struct packed {
        logic [STATUS_W-NUM_LAGS*LAG_W-1:0] zero;
        logic [NUM_LAGS-1:0][LAG_W-1:0]     lags;
    } lag_view_t;

    // band view, band and button in the low bits
    typedef struct packed {
        logic [STATUS_W-BAND_W-2:0] zero;
        logic [BAND_W-1:0]          band;
        logic                       btn;
    } band_view_t;

    // one readback word, decoded either way
    typedef union packed {
        lag_view_t  lag;
        band_view_t band;
    } status_word_u;

endpackage

/* design/servo_pkg.sv */
package servo_pkg;

    localparam int POS_W = 8;  // servo position
    localparam int DIR_W = 2;  // direction code

    // direction codes for the stepper
    localparam logic [DIR_W-1:0] DIR_HOLD = 2'b00;
    localparam logic [DIR_W-1:0] DIR_UP   = 2'b10;  // position up
    localparam logic [DIR_W-1:0] DIR_DOWN = 2'b01;  // position down

endpackage

/* design/result_capture.sv */
`timescale 1ns/1ns

module result_capture (
    input  logic                       lcd_vs,
    input  logic                       rst_n,
    input  logic                       result_valid_i,  // correlator result is done
    input  logic [loc_pkg::LAG_W-1:0]  lag1_i,
    input  logic [loc_pkg::LAG_W-1:0]  lag2_i,
    input  logic [loc_pkg::LAG_W-1:0]  lag3_i,
    input  logic [loc_pkg::LAG_W-1:0]  lag4_i,
    input  logic [loc_pkg::BAND_W-1:0] band_i,
    input  logic                       btn_i,
    output logic [loc_pkg::LAG_W-1:0]  lag1_o,
    output logic [loc_pkg::LAG_W-1:0]  lag2_o,
    output logic [loc_pkg::LAG_W-1:0]  lag3_o,
    output logic [loc_pkg::LAG_W-1:0]  lag4_o,
    output logic [loc_pkg::BAND_W-1:0] band_o,
    output logic                       btn_o,
    output logic                       fresh_o  // frame after a capture
);

    // held result, stays put while the correlator runs again
    always_ff @(posedge lcd_vs or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lag1_o <= '0;
            lag2_o <= '0;
            lag3_o <= '0;
            lag4_o <= '0;
            band_o <= '0;
            btn_o  <= 1'b0;
        end
        else if (result_valid_i)
        begin
            lag1_o <= lag1_i;
            lag2_o <= lag2_i;
            lag3_o <= lag3_i;
            lag4_o <= lag4_i;
            band_o <= band_i;
            btn_o  <= btn_i;
        end
    end

    // one frame wide, follows the valid level
    always_ff @(posedge lcd_vs or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fresh_o <= 1'b0;
        end
        else
        begin
            fresh_o <= result_valid_i;
        end
    end

endmodule

/* design/bearing_calc.sv */
`timescale 1ns/1ns

module bearing_calc #(
    parameter int DEADBAND = 2  // lag difference treated as centered
) (
    input  logic                        lcd_vs,
    input  logic                        rst_n,
    input  logic [loc_pkg::LAG_W-1:0]   lag1_i,
    input  logic [loc_pkg::LAG_W-1:0]   lag2_i,
    input  logic [loc_pkg::LAG_W-1:0]   lag3_i,
    input  logic [loc_pkg::LAG_W-1:0]   lag4_i,
    input  logic                        fresh_i,
    output logic [servo_pkg::DIR_W-1:0] pan_dir_o,
    output logic [servo_pkg::DIR_W-1:0] tilt_dir_o
);

    logic signed [loc_pkg::LAG_W:0] pan_diff;   // horizontal pair
    logic signed [loc_pkg::LAG_W:0] tilt_diff;  // vertical pair

    // direction from one lag difference, mirror swaps up and down
    function automatic logic [servo_pkg::DIR_W-1:0] dir_of(
        input logic signed [loc_pkg::LAG_W:0] diff,
        input logic                           mirror
    );
        logic [servo_pkg::DIR_W-1:0] pos_dir;
        logic [servo_pkg::DIR_W-1:0] neg_dir;
        pos_dir = mirror ? servo_pkg::DIR_DOWN : servo_pkg::DIR_UP;
        neg_dir = mirror ? servo_pkg::DIR_UP : servo_pkg::DIR_DOWN;
        if (diff > DEADBAND)
            return pos_dir;
        else if (diff < -DEADBAND)
            return neg_dir;
        else
            return servo_pkg::DIR_HOLD;  // inside deadband
    endfunction

    // lags are offset by 32, so the differences are signed around zero
    assign pan_diff  = $signed({1'b0, lag1_i}) - $signed({1'b0, lag2_i});
    assign tilt_diff = $signed({1'b0, lag3_i}) - $signed({1'b0, lag4_i});

    always_ff @(posedge lcd_vs or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pan_dir_o  <= servo_pkg::DIR_HOLD;
            tilt_dir_o <= servo_pkg::DIR_HOLD;
        end
        else if (fresh_i)
        begin
            pan_dir_o  <= dir_of(pan_diff, 1'b0);
            tilt_dir_o <= dir_of(tilt_diff, 1'b1);  // tilt servo sits reversed
        end
        else
        begin
            // no new result, one step per capture only
            pan_dir_o  <= servo_pkg::DIR_HOLD;
            tilt_dir_o <= servo_pkg::DIR_HOLD;
        end
    end

endmodule

/* design/servo_stepper.sv */
`timescale 1ns/1ns

module servo_stepper #(
    parameter int SERVO_MIN    = 16,
    parameter int SERVO_MAX    = 240,
    parameter int SERVO_CENTER = 128,  // reset position
    parameter int SERVO_STEP   = 4     // move per frame
) (
    input  logic                        lcd_vs,
    input  logic                        rst_n,
    input  logic [servo_pkg::DIR_W-1:0] pan_dir_i,
    input  logic [servo_pkg::DIR_W-1:0] tilt_dir_i,
    output logic [servo_pkg::POS_W-1:0] pan_pos_o,
    output logic [servo_pkg::POS_W-1:0] tilt_pos_o
);

    // next position for one axis, clamped to the limits
    function automatic logic [servo_pkg::POS_W-1:0] step_pos(
        input logic [servo_pkg::POS_W-1:0] pos,
        input logic [servo_pkg::DIR_W-1:0] dir
    );
        int next;
        next = int'(pos);
        case (dir)
            servo_pkg::DIR_UP:
            begin
                next = next + SERVO_STEP;
                if (next > SERVO_MAX)
                    next = SERVO_MAX;
            end
            servo_pkg::DIR_DOWN:
            begin
                next = next - SERVO_STEP;
                if (next < SERVO_MIN)
                    next = SERVO_MIN;  // int math, so no wrap below zero
            end
            default: next = int'(pos);  // hold, and the unused 11 code
        endcase
        return next[servo_pkg::POS_W-1:0];
    endfunction

    always_ff @(posedge lcd_vs or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pan_pos_o  <= SERVO_CENTER[servo_pkg::POS_W-1:0];
            tilt_pos_o <= SERVO_CENTER[servo_pkg::POS_W-1:0];
        end
        else
        begin
            pan_pos_o  <= step_pos(pan_pos_o, pan_dir_i);
            tilt_pos_o <= step_pos(tilt_pos_o, tilt_dir_i);
        end
    end

endmodule

/* design/status_word.sv */
`timescale 1ns/1ns

module status_word #(
    parameter int BLINK_BIT = 3  // led toggles every 2**BLINK_BIT frames
) (
    input  logic                         lcd_vs,
    input  logic                         rst_n,
    input  logic [loc_pkg::LAG_W-1:0]    lag1_i,
    input  logic [loc_pkg::LAG_W-1:0]    lag2_i,
    input  logic [loc_pkg::LAG_W-1:0]    lag3_i,
    input  logic [loc_pkg::LAG_W-1:0]    lag4_i,
    input  logic [loc_pkg::BAND_W-1:0]   band_i,
    input  logic                         btn_i,
    input  logic                         status_sel_i,  // 0 lag view, 1 band view
    output logic [loc_pkg::STATUS_W-1:0] status_word_o,
    output logic                         led_o
);

    loc_pkg::status_word_u word;
    logic [BLINK_BIT:0]    frame_cnt;

    // readback word, straight from the held result
    always_comb
    begin
        word = '0;
        if (status_sel_i)
        begin
            word.band.band = band_i;
            word.band.btn  = btn_i;
        end
        else
        begin
            word.lag.lags = {lag1_i, lag2_i, lag3_i, lag4_i};  // lag1 on top
        end
    end

    assign status_word_o = word;

    // frame counter, wraps freely
    always_ff @(posedge lcd_vs or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_cnt <= '0;
        end
        else
        begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    assign led_o = frame_cnt[BLINK_BIT];  // blinks while frame sync runs

endmodule

/* design/loc_top.sv */
`timescale 1ns/1ns

module loc_top #(
    parameter int DEADBAND     = 2,
    parameter int SERVO_MIN    = 16,
    parameter int SERVO_MAX    = 240,
    parameter int SERVO_CENTER = 128,
    parameter int SERVO_STEP   = 4,
    parameter int BLINK_BIT    = 3
) (
    input  logic                         lcd_vs,  // frame sync as clock
    input  logic                         rst_n,
    input  logic                         result_valid_i,
    input  logic [loc_pkg::LAG_W-1:0]    lag1_i,
    input  logic [loc_pkg::LAG_W-1:0]    lag2_i,
    input  logic [loc_pkg::LAG_W-1:0]    lag3_i,
    input  logic [loc_pkg::LAG_W-1:0]    lag4_i,
    input  logic [loc_pkg::BAND_W-1:0]   band_i,
    input  logic                         btn_i,
    input  logic                         status_sel_i,
    output logic [servo_pkg::POS_W-1:0]  pan_pos_o,
    output logic [servo_pkg::POS_W-1:0]  tilt_pos_o,
    output logic                         fresh_o,
    output logic [loc_pkg::STATUS_W-1:0] status_word_o,
    output logic                         led_o
);

    // held result
    logic [loc_pkg::LAG_W-1:0]    lag1_q;
    logic [loc_pkg::LAG_W-1:0]    lag2_q;
    logic [loc_pkg::LAG_W-1:0]    lag3_q;
    logic [loc_pkg::LAG_W-1:0]    lag4_q;
    logic [loc_pkg::BAND_W-1:0]   band_q;
    logic                         btn_q;
    logic [servo_pkg::DIR_W-1:0]  pan_dir;
    logic [servo_pkg::DIR_W-1:0]  tilt_dir;

    result_capture u_capture (
        .lcd_vs         (lcd_vs),
        .rst_n          (rst_n),
        .result_valid_i (result_valid_i),
        .lag1_i         (lag1_i),
        .lag2_i         (lag2_i),
        .lag3_i         (lag3_i),
        .lag4_i         (lag4_i),
        .band_i         (band_i),
        .btn_i          (btn_i),
        .lag1_o         (lag1_q),
        .lag2_o         (lag2_q),
        .lag3_o         (lag3_q),
        .lag4_o         (lag4_q),
        .band_o         (band_q),
        .btn_o          (btn_q),
        .fresh_o        (fresh_o)
    );

    bearing_calc #(.DEADBAND(DEADBAND)) u_bearing (
        .lcd_vs     (lcd_vs),
        .rst_n      (rst_n),
        .lag1_i     (lag1_q),
        .lag2_i     (lag2_q),
        .lag3_i     (lag3_q),
        .lag4_i     (lag4_q),
        .fresh_i    (fresh_o),  // strobe for the direction update
        .pan_dir_o  (pan_dir),
        .tilt_dir_o (tilt_dir)
    );

    servo_stepper #(
        .SERVO_MIN    (SERVO_MIN),
        .SERVO_MAX    (SERVO_MAX),
        .SERVO_CENTER (SERVO_CENTER),
        .SERVO_STEP   (SERVO_STEP)
    ) u_stepper (
        .lcd_vs     (lcd_vs),
        .rst_n      (rst_n),
        .pan_dir_i  (pan_dir),
        .tilt_dir_i (tilt_dir),
        .pan_pos_o  (pan_pos_o),
        .tilt_pos_o (tilt_pos_o)
    );

    status_word #(.BLINK_BIT(BLINK_BIT)) u_status (
        .lcd_vs        (lcd_vs),
        .rst_n         (rst_n),
        .lag1_i        (lag1_q),
        .lag2_i        (lag2_q),
        .lag3_i        (lag3_q),
        .lag4_i        (lag4_q),
        .band_i        (band_q),
        .btn_i         (btn_q),
        .status_sel_i  (status_sel_i),
        .status_word_o (status_word_o),
        .led_o         (led_o)
    );

endmodule

/* tests/loc_vectors.svh */
`ifndef LOC_VECTORS_SVH
`define LOC_VECTORS_SVH

// columns: repeat count, valid, lag1..lag4, band, button, select, expected status word
// idle rows (valid 0) get random lags and band at run time, their lag fields are unused
typedef struct packed {
    int                         rep;
    logic                       valid;
    logic [loc_pkg::LAG_W-1:0]  lag1;
    logic [loc_pkg::LAG_W-1:0]  lag2;
    logic [loc_pkg::LAG_W-1:0]  lag3;
    logic [loc_pkg::LAG_W-1:0]  lag4;
    logic [loc_pkg::BAND_W-1:0] band;
    logic                       btn;
    logic                       sel;
    logic [31:0]                exp_status;
} vec_t;

localparam int NUM_VECTORS = 13;

// positions are not listed here, the testbench model tracks them row by row
localparam vec_t VECTORS [NUM_VECTORS] = '{
    // pan pair +8, one step up
    '{1,  1'b1, 6'd40, 6'd32, 6'd32, 6'd32, 9'h0a5, 1'b1, 1'b0, 32'h00a2_0820},
    '{3,  1'b0, 6'd0,  6'd0,  6'd0,  6'd0,  9'h000, 1'b0, 1'b0, 32'h00a2_0820},
    '{1,  1'b0, 6'd0,  6'd0,  6'd0,  6'd0,  9'h000, 1'b0, 1'b1, 32'h0000_014b},
    // pan pair +1, inside deadband
    '{1,  1'b1, 6'd33, 6'd32, 6'd32, 6'd32, 9'h1ff, 1'b0, 1'b1, 32'h0000_03fe},
    '{3,  1'b0, 6'd0,  6'd0,  6'd0,  6'd0,  9'h000, 1'b0, 1'b1, 32'h0000_03fe},
    // pan pair -2, right on the deadband edge
    '{1,  1'b1, 6'd30, 6'd32, 6'd32, 6'd32, 9'h011, 1'b1, 1'b0, 32'h007a_0820},
    '{3,  1'b0, 6'd0,  6'd0,  6'd0,  6'd0,  9'h000, 1'b0, 1'b0, 32'h007a_0820},
    // tilt pair +8, tilt goes down
    '{1,  1'b1, 6'd32, 6'd32, 6'd40, 6'd32, 9'h055, 1'b0, 1'b0, 32'h0082_0a20},
    '{3,  1'b0, 6'd0,  6'd0,  6'd0,  6'd0,  9'h000, 1'b0, 1'b0, 32'h0082_0a20},
    // tilt pair -12, tilt goes up
    '{1,  1'b1, 6'd32, 6'd32, 6'd20, 6'd32, 9'h100, 1'b1, 1'b1, 32'h0000_0201},
    '{3,  1'b0, 6'd0,  6'd0,  6'd0,  6'd0,  9'h000, 1'b0, 1'b0, 32'h0082_0520},
    // long burst, pan runs into the top limit and tilt into the bottom
    '{32, 1'b1, 6'd50, 6'd32, 6'd50, 6'd32, 9'h0c3, 1'b0, 1'b0, 32'h00ca_0ca0},
    '{4,  1'b0, 6'd0,  6'd0,  6'd0,  6'd0,  9'h000, 1'b0, 1'b1, 32'h0000_0186}
};

`endif

/* tests/tb_loc_top.sv */
`timescale 1ns/1ns

module tb_loc_top;

    localparam int DEADBAND     = 2;
    localparam int SERVO_MIN    = 16;
    localparam int SERVO_MAX    = 240;
    localparam int SERVO_CENTER = 128;
    localparam int SERVO_STEP   = 4;
    localparam int BLINK_BIT    = 3;
    localparam int RESET_CYCLES = 4;

    `include "loc_vectors.svh"

    logic                         lcd_vs;
    logic                         rst_n;
    logic                         result_valid_i;
    logic [loc_pkg::LAG_W-1:0]    lag1_i;
    logic [loc_pkg::LAG_W-1:0]    lag2_i;
    logic [loc_pkg::LAG_W-1:0]    lag3_i;
    logic [loc_pkg::LAG_W-1:0]    lag4_i;
    logic [loc_pkg::BAND_W-1:0]   band_i;
    logic                         btn_i;
    logic                         status_sel_i;
    logic [servo_pkg::POS_W-1:0]  pan_pos_o;
    logic [servo_pkg::POS_W-1:0]  tilt_pos_o;
    logic                         fresh_o;
    logic [loc_pkg::STATUS_W-1:0] status_word_o;
    logic                         led_o;

    int cycle_cnt;
    // reference model state
    int m_pan;
    int m_tilt;
    int m_pan_dir;   // +1 up, -1 down, 0 hold
    int m_tilt_dir;
    int m_fresh;
    int m_frames;    // edges since reset release
    int m_lag [4];

    loc_top #(
        .DEADBAND     (DEADBAND),
        .SERVO_MIN    (SERVO_MIN),
        .SERVO_MAX    (SERVO_MAX),
        .SERVO_CENTER (SERVO_CENTER),
        .SERVO_STEP   (SERVO_STEP),
        .BLINK_BIT    (BLINK_BIT)
    ) uut (
        .lcd_vs         (lcd_vs),
        .rst_n          (rst_n),
        .result_valid_i (result_valid_i),
        .lag1_i         (lag1_i),
        .lag2_i         (lag2_i),
        .lag3_i         (lag3_i),
        .lag4_i         (lag4_i),
        .band_i         (band_i),
        .btn_i          (btn_i),
        .status_sel_i   (status_sel_i),
        .pan_pos_o      (pan_pos_o),
        .tilt_pos_o     (tilt_pos_o),
        .fresh_o        (fresh_o),
        .status_word_o  (status_word_o),
        .led_o          (led_o)
    );

    initial
    begin
        lcd_vs = 1'b0;
        forever #5 lcd_vs = ~lcd_vs;  // 10 ns frame period
    end

    function automatic int total_frames();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_VECTORS; i++)
            sum += VECTORS[i].rep;
        return sum;
    endfunction

    function automatic int clamp_pos(input int p);
        if (p > SERVO_MAX)
            return SERVO_MAX;
        if (p < SERVO_MIN)
            return SERVO_MIN;
        return p;
    endfunction

    // sign of a lag difference outside the deadband
    function automatic int bearing_sign(input int diff);
        if (diff > DEADBAND)
            return 1;
        if (diff < -DEADBAND)
            return -1;
        return 0;
    endfunction

    // advance the expected pipeline by one frame edge starting with the oldest stage
    task automatic model_edge();
        m_pan  = clamp_pos(m_pan + m_pan_dir * SERVO_STEP);
        m_tilt = clamp_pos(m_tilt + m_tilt_dir * SERVO_STEP);
        if (m_fresh != 0)
        begin
            m_pan_dir  = bearing_sign(m_lag[0] - m_lag[1]);
            m_tilt_dir = -bearing_sign(m_lag[2] - m_lag[3]);  // reversed mount
        end
        else
        begin
            m_pan_dir  = 0;
            m_tilt_dir = 0;
        end
        m_fresh = result_valid_i;
        if (result_valid_i)
        begin
            m_lag[0] = lag1_i;
            m_lag[1] = lag2_i;
            m_lag[2] = lag3_i;
            m_lag[3] = lag4_i;
        end
        m_frames++;
    endtask

    task automatic compare_hex(input int idx, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("[FAIL] %s row %0d got 0x%08h expected 0x%08h", name, idx, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_outputs(input int idx, input logic [31:0] exp_status);
        compare_hex(idx, "status_word_o", status_word_o, exp_status);
        compare_hex(idx, "pan_pos_o", pan_pos_o, m_pan);
        compare_hex(idx, "tilt_pos_o", tilt_pos_o, m_tilt);
        compare_hex(idx, "fresh_o", fresh_o, m_fresh);
        compare_hex(idx, "led_o", led_o, (m_frames >> BLINK_BIT) & 1);
    endtask

    task automatic apply_inputs(input vec_t v);
        result_valid_i = v.valid;
        status_sel_i   = v.sel;
        btn_i          = v.btn;
        if (v.valid)
        begin
            lag1_i = v.lag1;
            lag2_i = v.lag2;
            lag3_i = v.lag3;
            lag4_i = v.lag4;
            band_i = v.band;
        end
        else
        begin
            // correlator output is garbage on idle frames
            lag1_i = $urandom_range(63, 0);
            lag2_i = $urandom_range(63, 0);
            lag3_i = $urandom_range(63, 0);
            lag4_i = $urandom_range(63, 0);
            band_i = $urandom_range(511, 0);
        end
    endtask

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt <= total_frames() + RESET_CYCLES + 20)
        begin
            @(posedge lcd_vs);
            cycle_cnt++;
        end
        $display("timeout: the vector table did not finish in %0d frames", cycle_cnt);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped by timeout");
    end

    initial
    begin
        void'($urandom(82713));
        rst_n          = 1'b0;
        result_valid_i = 1'b0;
        lag1_i         = '0;
        lag2_i         = '0;
        lag3_i         = '0;
        lag4_i         = '0;
        band_i         = '0;
        btn_i          = 1'b0;
        status_sel_i   = 1'b0;
        m_pan          = SERVO_CENTER;
        m_tilt         = SERVO_CENTER;
        m_pan_dir      = 0;
        m_tilt_dir     = 0;
        m_fresh        = 0;
        m_frames       = 0;
        m_lag          = '{0, 0, 0, 0};

        repeat (RESET_CYCLES) @(posedge lcd_vs);
        #1;
        rst_n = 1'b1;
        check_outputs(-1, 32'h0);  // values straight out of reset

        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            for (int r = 0; r < VECTORS[i].rep; r++)
            begin
                apply_inputs(VECTORS[i]);
                @(posedge lcd_vs);
                #1;
                model_edge();
                check_outputs(i, VECTORS[i].exp_status);
            end
        end

        // the burst has to end on both limits
        compare_hex(NUM_VECTORS, "pan_pos_o", pan_pos_o, SERVO_MAX);
        compare_hex(NUM_VECTORS, "tilt_pos_o", tilt_pos_o, SERVO_MIN);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* project.f */
+incdir+tests
design/loc_pkg.sv
design/servo_pkg.sv
design/result_capture.sv
design/bearing_calc.sv
design/servo_stepper.sv
design/status_word.sv
design/loc_top.sv
tests/tb_loc_top.sv

/* Bender.yml */
package:
  name: loc_top

sources:
  - design/loc_pkg.sv
  - design/servo_pkg.sv
  - design/result_capture.sv
  - design/bearing_calc.sv
  - design/servo_stepper.sv
  - design/status_word.sv
  - design/loc_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_loc_top.sv
